// File: hdl/dual_issue_pkg.sv
package dual_issue_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;
    localparam int CREDIT_W   = 2;

    // Internal ALU operations
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd10;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd11;

    // MIPS opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // MIPS funct field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } inst_word_t;

endpackage

// File: hdl/inst_queue.sv
module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 inst_valid,
    input  dual_issue_pkg::inst_word_t           inst_data,
    input  logic                                 pop_master,
    input  logic                                 pop_slave,
    output dual_issue_pkg::inst_word_t           head0,
    output dual_issue_pkg::inst_word_t           head1,
    output logic                                 head0_valid,
    output logic                                 head1_valid,
    output logic [dual_issue_pkg::CREDIT_W-1:0]  inst_credit
);
    import dual_issue_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    inst_word_t          mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W:0]      count;
    logic [CREDIT_W-1:0] pop_count;

    assign pop_count = CREDIT_W'(pop_master) + CREDIT_W'(pop_slave);

    // Oldest two entries
    assign head0       = mem[rd_ptr];
    assign head1       = mem[rd_ptr + PTR_W'(1)];
    assign head0_valid = count != '0;
    assign head1_valid = count > (PTR_W+1)'(1);

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            mem[wr_ptr] <= inst_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            inst_credit <= '0;
        end else begin
            rd_ptr      <= rd_ptr + PTR_W'(pop_count);
            wr_ptr      <= wr_ptr + PTR_W'(inst_valid);
            count       <= count + (PTR_W+1)'(inst_valid) - (PTR_W+1)'(pop_count);
            // Freed slots go back to the sender next cycle
            inst_credit <= pop_count;
        end
    end

endmodule

// File: hdl/inst_decoder.sv
module inst_decoder (
    input  dual_issue_pkg::inst_word_t             inst,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]  rs,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]  rt,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]  dest,
    output logic                                   uses_rs,
    output logic                                   uses_rt,
    output logic                                   wen,
    output logic [dual_issue_pkg::ALU_OP_W-1:0]    alu_op,
    output logic                                   use_imm,
    output logic                                   imm_zero_ext,
    output logic                                   use_shamt,
    output logic [15:0]                            imm16,
    output logic [4:0]                             shamt
);
    import dual_issue_pkg::*;

    logic is_r;
    logic defined;

    // rs and rt sit at the same bits in both formats
    assign is_r  = inst.r.opcode == OP_SPECIAL;
    assign rs    = inst.r.rs;
    assign rt    = inst.r.rt;
    assign dest  = is_r ? inst.r.rd : inst.i.rt;
    assign imm16 = inst.i.imm16;
    assign shamt = inst.r.shamt;
    assign wen   = defined && (dest != '0);

    always_comb begin
        alu_op       = ALU_ADD;
        use_imm      = !is_r;
        imm_zero_ext = 1'b0;
        use_shamt    = 1'b0;
        uses_rs      = 1'b1;
        uses_rt      = is_r;
        defined      = 1'b1;
        if (is_r) begin
            case (inst.r.funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                FN_SLL, FN_SRL, FN_SRA: begin
                    // Fixed shifts only read rt
                    alu_op    = (inst.r.funct == FN_SLL) ? ALU_SLL :
                                (inst.r.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    use_shamt = 1'b1;
                    uses_rs   = 1'b0;
                end
                default: defined = 1'b0;
            endcase
        end else begin
            case (inst.i.opcode)
                OP_ADDIU: alu_op = ALU_ADD;
                OP_SLTI:  alu_op = ALU_SLT;
                OP_ANDI, OP_ORI, OP_XORI: begin
                    alu_op       = (inst.i.opcode == OP_ANDI) ? ALU_AND :
                                   (inst.i.opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
                    imm_zero_ext = 1'b1;
                end
                OP_LUI: begin
                    alu_op  = ALU_LUI;
                    uses_rs = 1'b0;
                end
                default: defined = 1'b0;
            endcase
        end
        // Bubble reads nothing
        if (!defined) begin
            uses_rs = 1'b0;
            uses_rt = 1'b0;
        end
    end

endmodule

// File: hdl/issue_ctrl.sv
module issue_ctrl (
    input  logic                                   head0_valid,
    input  logic                                   head1_valid,
    input  logic                                   master_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  master_dest,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  slave_rs,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  slave_rt,
    input  logic                                   slave_uses_rs,
    input  logic                                   slave_uses_rt,
    output logic                                   issue_master,
    output logic                                   issue_slave
);

    logic raw_hazard;

    // Slave reading the master result must wait a cycle
    assign raw_hazard = master_wen &&
                        ((slave_uses_rs && (slave_rs == master_dest)) ||
                         (slave_uses_rt && (slave_rt == master_dest)));

    assign issue_master = head0_valid;
    assign issue_slave  = head0_valid && head1_valid && !raw_hazard;

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  raddr0,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  raddr1,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  raddr2,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  raddr3,
    output logic [dual_issue_pkg::DATA_W-1:0]      rdata0,
    output logic [dual_issue_pkg::DATA_W-1:0]      rdata1,
    output logic [dual_issue_pkg::DATA_W-1:0]      rdata2,
    output logic [dual_issue_pkg::DATA_W-1:0]      rdata3,
    input  logic                                   wen_master,
    input  logic                                   wen_slave,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  waddr_master,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  waddr_slave,
    input  logic [dual_issue_pkg::DATA_W-1:0]      wdata_master,
    input  logic [dual_issue_pkg::DATA_W-1:0]      wdata_slave
);
    import dual_issue_pkg::*;

    logic [DATA_W-1:0] regs [32];

    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen_master) begin
                regs[waddr_master] <= wdata_master;
            end
            // Younger lane last so it wins a collision
            if (wen_slave) begin
                regs[waddr_slave] <= wdata_slave;
            end
        end
    end

endmodule

// File: hdl/operand_bypass.sv
module operand_bypass (
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  src_addr,
    input  logic [dual_issue_pkg::DATA_W-1:0]      rf_data,
    input  logic                                   ex_slave_wen,
    input  logic                                   ex_master_wen,
    input  logic                                   wb_slave_wen,
    input  logic                                   wb_master_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  ex_slave_dest,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  ex_master_dest,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  wb_slave_dest,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]  wb_master_dest,
    input  logic [dual_issue_pkg::DATA_W-1:0]      ex_slave_data,
    input  logic [dual_issue_pkg::DATA_W-1:0]      ex_master_data,
    input  logic [dual_issue_pkg::DATA_W-1:0]      wb_slave_data,
    input  logic [dual_issue_pkg::DATA_W-1:0]      wb_master_data,
    output logic [dual_issue_pkg::DATA_W-1:0]      value
);

    // Newest writer first; r0 always comes from the file
    always_comb begin
        if (src_addr == '0) begin
            value = rf_data;
        end else if (ex_slave_wen && ex_slave_dest == src_addr) begin
            value = ex_slave_data;
        end else if (ex_master_wen && ex_master_dest == src_addr) begin
            value = ex_master_data;
        end else if (wb_slave_wen && wb_slave_dest == src_addr) begin
            value = wb_slave_data;
        end else if (wb_master_wen && wb_master_dest == src_addr) begin
            value = wb_master_data;
        end else begin
            value = rf_data;
        end
    end

endmodule

// File: hdl/int_alu.sv
module int_alu (
    input  logic [dual_issue_pkg::ALU_OP_W-1:0]  alu_op,
    input  logic [dual_issue_pkg::DATA_W-1:0]    rs_value,
    input  logic [dual_issue_pkg::DATA_W-1:0]    rt_value,
    input  logic                                 use_imm,
    input  logic                                 imm_zero_ext,
    input  logic                                 use_shamt,
    input  logic [15:0]                          imm16,
    input  logic [4:0]                           shamt,
    output logic [dual_issue_pkg::DATA_W-1:0]    result
);
    import dual_issue_pkg::*;

    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] op_b;
    logic [4:0]        sh_amt;

    assign imm_ext = imm_zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    assign op_b    = use_imm ? imm_ext : rt_value;
    // Variable shift amount taken from rs when shamt is not selected
    assign sh_amt  = use_shamt ? shamt : rs_value[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = rs_value + op_b;
            ALU_SUB:  result = rs_value - op_b;
            ALU_AND:  result = rs_value & op_b;
            ALU_OR:   result = rs_value | op_b;
            ALU_XOR:  result = rs_value ^ op_b;
            ALU_NOR:  result = ~(rs_value | op_b);
            ALU_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(rs_value) < $signed(op_b)};
            ALU_SLTU: result = {{(DATA_W-1){1'b0}}, rs_value < op_b};
            ALU_SLL:  result = op_b << sh_amt;
            ALU_SRL:  result = op_b >> sh_amt;
            ALU_SRA:  result = $signed(op_b) >>> sh_amt;
            ALU_LUI:  result = {imm16, 16'b0};
            default:  result = '0;
        endcase
    end

endmodule

// File: hdl/dual_issue_core.sv
module dual_issue_core #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   inst_valid,
    input  logic [dual_issue_pkg::DATA_W-1:0]      inst_data,
    output logic [dual_issue_pkg::CREDIT_W-1:0]    inst_credit,
    output logic                                   wb_master_en,
    output logic                                   wb_slave_en,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]  wb_master_dest,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0]  wb_slave_dest,
    output logic [dual_issue_pkg::DATA_W-1:0]      wb_master_data,
    output logic [dual_issue_pkg::DATA_W-1:0]      wb_slave_data
);
    import dual_issue_pkg::*;

    inst_word_t            head0, head1;
    logic                  head0_valid, head1_valid;
    logic                  issue_master, issue_slave;

    // Decode outputs, m_ master lane, s_ slave lane
    logic [REG_ADDR_W-1:0] m_rs, m_rt, m_dest, s_rs, s_rt, s_dest;
    logic                  m_wen, m_use_imm, m_imm_zero_ext, m_use_shamt;
    logic                  s_wen, s_use_imm, s_imm_zero_ext, s_use_shamt;
    logic                  s_uses_rs, s_uses_rt;
    logic [ALU_OP_W-1:0]   m_alu_op, s_alu_op;
    logic [15:0]           m_imm16, s_imm16;
    logic [4:0]            m_shamt, s_shamt;
    logic [DATA_W-1:0]     rf_m_rs, rf_m_rt, rf_s_rs, rf_s_rt;
    logic [DATA_W-1:0]     m_rs_val, m_rt_val, s_rs_val, s_rt_val;

    // ID/EX lane registers
    logic                  ex_m_valid, ex_s_valid;
    logic [REG_ADDR_W-1:0] ex_m_dest, ex_s_dest;
    logic [ALU_OP_W-1:0]   ex_m_alu_op, ex_s_alu_op;
    logic                  ex_m_use_imm, ex_m_imm_zero_ext, ex_m_use_shamt;
    logic                  ex_s_use_imm, ex_s_imm_zero_ext, ex_s_use_shamt;
    logic [15:0]           ex_m_imm16, ex_s_imm16;
    logic [4:0]            ex_m_shamt, ex_s_shamt;
    logic [DATA_W-1:0]     ex_m_rs_val, ex_m_rt_val, ex_s_rs_val, ex_s_rt_val;
    logic [DATA_W-1:0]     ex_m_result, ex_s_result;

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_data(inst_data),
        .pop_master(issue_master), .pop_slave(issue_slave),
        .head0(head0), .head1(head1), .head0_valid(head0_valid),
        .head1_valid(head1_valid), .inst_credit(inst_credit)
    );

    inst_decoder u_dec_master (
        .inst(head0), .rs(m_rs), .rt(m_rt), .dest(m_dest), .uses_rs(), .uses_rt(),
        .wen(m_wen), .alu_op(m_alu_op), .use_imm(m_use_imm),
        .imm_zero_ext(m_imm_zero_ext), .use_shamt(m_use_shamt),
        .imm16(m_imm16), .shamt(m_shamt)
    );

    inst_decoder u_dec_slave (
        .inst(head1), .rs(s_rs), .rt(s_rt), .dest(s_dest),
        .uses_rs(s_uses_rs), .uses_rt(s_uses_rt),
        .wen(s_wen), .alu_op(s_alu_op), .use_imm(s_use_imm),
        .imm_zero_ext(s_imm_zero_ext), .use_shamt(s_use_shamt),
        .imm16(s_imm16), .shamt(s_shamt)
    );

    issue_ctrl u_issue (
        .head0_valid(head0_valid), .head1_valid(head1_valid),
        .master_wen(m_wen), .master_dest(m_dest),
        .slave_rs(s_rs), .slave_rt(s_rt),
        .slave_uses_rs(s_uses_rs), .slave_uses_rt(s_uses_rt),
        .issue_master(issue_master), .issue_slave(issue_slave)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst),
        .raddr0(m_rs), .raddr1(m_rt), .raddr2(s_rs), .raddr3(s_rt),
        .rdata0(rf_m_rs), .rdata1(rf_m_rt), .rdata2(rf_s_rs), .rdata3(rf_s_rt),
        .wen_master(wb_master_en), .wen_slave(wb_slave_en),
        .waddr_master(wb_master_dest), .waddr_slave(wb_slave_dest),
        .wdata_master(wb_master_data), .wdata_slave(wb_slave_data)
    );

    operand_bypass u_byp_m_rs (
        .src_addr(m_rs), .rf_data(rf_m_rs), .value(m_rs_val),
        .ex_slave_wen(ex_s_valid), .ex_slave_dest(ex_s_dest), .ex_slave_data(ex_s_result),
        .ex_master_wen(ex_m_valid), .ex_master_dest(ex_m_dest), .ex_master_data(ex_m_result),
        .wb_slave_wen(wb_slave_en), .wb_slave_dest(wb_slave_dest), .wb_slave_data(wb_slave_data),
        .wb_master_wen(wb_master_en), .wb_master_dest(wb_master_dest),
        .wb_master_data(wb_master_data)
    );

    operand_bypass u_byp_m_rt (
        .src_addr(m_rt), .rf_data(rf_m_rt), .value(m_rt_val),
        .ex_slave_wen(ex_s_valid), .ex_slave_dest(ex_s_dest), .ex_slave_data(ex_s_result),
        .ex_master_wen(ex_m_valid), .ex_master_dest(ex_m_dest), .ex_master_data(ex_m_result),
        .wb_slave_wen(wb_slave_en), .wb_slave_dest(wb_slave_dest), .wb_slave_data(wb_slave_data),
        .wb_master_wen(wb_master_en), .wb_master_dest(wb_master_dest),
        .wb_master_data(wb_master_data)
    );

    operand_bypass u_byp_s_rs (
        .src_addr(s_rs), .rf_data(rf_s_rs), .value(s_rs_val),
        .ex_slave_wen(ex_s_valid), .ex_slave_dest(ex_s_dest), .ex_slave_data(ex_s_result),
        .ex_master_wen(ex_m_valid), .ex_master_dest(ex_m_dest), .ex_master_data(ex_m_result),
        .wb_slave_wen(wb_slave_en), .wb_slave_dest(wb_slave_dest), .wb_slave_data(wb_slave_data),
        .wb_master_wen(wb_master_en), .wb_master_dest(wb_master_dest),
        .wb_master_data(wb_master_data)
    );

    operand_bypass u_byp_s_rt (
        .src_addr(s_rt), .rf_data(rf_s_rt), .value(s_rt_val),
        .ex_slave_wen(ex_s_valid), .ex_slave_dest(ex_s_dest), .ex_slave_data(ex_s_result),
        .ex_master_wen(ex_m_valid), .ex_master_dest(ex_m_dest), .ex_master_data(ex_m_result),
        .wb_slave_wen(wb_slave_en), .wb_slave_dest(wb_slave_dest), .wb_slave_data(wb_slave_data),
        .wb_master_wen(wb_master_en), .wb_master_dest(wb_master_dest),
        .wb_master_data(wb_master_data)
    );

    // Lane valids mean "carries a register write"; a lane not issued is a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_m_valid   <= 1'b0;
            ex_s_valid   <= 1'b0;
            wb_master_en <= 1'b0;
            wb_slave_en  <= 1'b0;
        end else begin
            ex_m_valid   <= issue_master && m_wen;
            ex_s_valid   <= issue_slave && s_wen;
            wb_master_en <= ex_m_valid;
            wb_slave_en  <= ex_s_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_m_dest         <= m_dest;
        ex_m_alu_op       <= m_alu_op;
        ex_m_use_imm      <= m_use_imm;
        ex_m_imm_zero_ext <= m_imm_zero_ext;
        ex_m_use_shamt    <= m_use_shamt;
        ex_m_imm16        <= m_imm16;
        ex_m_shamt        <= m_shamt;
        ex_m_rs_val       <= m_rs_val;
        ex_m_rt_val       <= m_rt_val;
        ex_s_dest         <= s_dest;
        ex_s_alu_op       <= s_alu_op;
        ex_s_use_imm      <= s_use_imm;
        ex_s_imm_zero_ext <= s_imm_zero_ext;
        ex_s_use_shamt    <= s_use_shamt;
        ex_s_imm16        <= s_imm16;
        ex_s_shamt        <= s_shamt;
        ex_s_rs_val       <= s_rs_val;
        ex_s_rt_val       <= s_rt_val;
        // EX/WB payload
        wb_master_dest    <= ex_m_dest;
        wb_master_data    <= ex_m_result;
        wb_slave_dest     <= ex_s_dest;
        wb_slave_data     <= ex_s_result;
    end

    int_alu u_alu_master (
        .alu_op(ex_m_alu_op), .rs_value(ex_m_rs_val), .rt_value(ex_m_rt_val),
        .use_imm(ex_m_use_imm), .imm_zero_ext(ex_m_imm_zero_ext),
        .use_shamt(ex_m_use_shamt), .imm16(ex_m_imm16), .shamt(ex_m_shamt),
        .result(ex_m_result)
    );

    int_alu u_alu_slave (
        .alu_op(ex_s_alu_op), .rs_value(ex_s_rs_val), .rt_value(ex_s_rt_val),
        .use_imm(ex_s_use_imm), .imm_zero_ext(ex_s_imm_zero_ext),
        .use_shamt(ex_s_use_shamt), .imm16(ex_s_imm16), .shamt(ex_s_shamt),
        .result(ex_s_result)
    );

endmodule

// File: tb/tb_dual_issue.sv
module tb_dual_issue;
    timeunit 1ns;
    timeprecision 1ps;

    import dual_issue_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int NUM_INST    = 2000;
    localparam int SEND_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst_data;
    logic [1:0]  inst_credit;
    logic        wb_master_en;
    logic        wb_slave_en;
    logic [4:0]  wb_master_dest;
    logic [4:0]  wb_slave_dest;
    logic [31:0] wb_master_data;
    logic [31:0] wb_slave_data;

    logic [31:0] rng_state = 32'd52;
    logic [31:0] model_regs [32];
    logic [4:0]  exp_dest [$];
    logic [31:0] exp_data [$];
    int          value_errs;
    int          other_errs;
    int          retired;
    int          exp_total;
    int          sent;
    int          credits;
    int          cycles;

    dual_issue_core #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_data(inst_data),
        .inst_credit(inst_credit),
        .wb_master_en(wb_master_en), .wb_slave_en(wb_slave_en),
        .wb_master_dest(wb_master_dest), .wb_slave_dest(wb_slave_dest),
        .wb_master_data(wb_master_data), .wb_slave_data(wb_slave_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Low bits of the LCG have short periods
    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return r[31:16] % n;
    endfunction

    function automatic logic [31:0] make_instruction();
        int unsigned kind;
        int unsigned pick;
        logic [4:0]  rs, rt, rd, sh;
        logic [15:0] imm;
        logic [5:0]  fn;
        logic [5:0]  opc;
        kind = rand_below(32);
        // Small register window keeps dependencies frequent
        rs   = 5'(rand_below(8));
        rt   = 5'(rand_below(8));
        rd   = 5'(rand_below(8));
        sh   = 5'(rand_below(32));
        imm  = 16'(rand_below(65536));
        if (kind < 14) begin
            pick = rand_below(11);
            case (pick)
                0:       fn = FN_ADDU;
                1:       fn = FN_SUBU;
                2:       fn = FN_AND;
                3:       fn = FN_OR;
                4:       fn = FN_XOR;
                5:       fn = FN_NOR;
                6:       fn = FN_SLT;
                7:       fn = FN_SLL;
                8:       fn = FN_SRL;
                9:       fn = FN_SRA;
                default: fn = FN_SLTU;
            endcase
            return {OP_SPECIAL, rs, rt, rd, sh, fn};
        end else if (kind < 29) begin
            pick = rand_below(6);
            case (pick)
                0:       opc = OP_ADDIU;
                1:       opc = OP_SLTI;
                2:       opc = OP_ANDI;
                3:       opc = OP_ORI;
                4:       opc = OP_XORI;
                default: opc = OP_LUI;
            endcase
            return {opc, rs, rt, imm};
        end else if (kind < 31) begin
            // LW opcode is not part of this core
            return {6'h23, rs, rt, imm};
        end else begin
            // MULT funct
            return {OP_SPECIAL, rs, rt, rd, sh, 6'h18};
        end
    endfunction

    // Reference ISA semantics for one word in program order
    task automatic run_model(input logic [31:0] word);
        logic [5:0]  opc, fn;
        logic [4:0]  rs, rt, rd, sh, dest;
        logic [15:0] imm;
        logic [31:0] a, b, sext, zext, res;
        bit          writes;
        opc    = word[31:26];
        rs     = word[25:21];
        rt     = word[20:16];
        rd     = word[15:11];
        sh     = word[10:6];
        fn     = word[5:0];
        imm    = word[15:0];
        a      = model_regs[rs];
        b      = model_regs[rt];
        sext   = {{16{imm[15]}}, imm};
        zext   = {16'h0000, imm};
        writes = 1'b1;
        res    = '0;
        if (opc == OP_SPECIAL) begin
            dest = rd;
            case (fn)
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_NOR:  res = ~(a | b);
                FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                FN_SLL:  res = b << sh;
                FN_SRL:  res = b >> sh;
                FN_SRA:  res = $signed(b) >>> sh;
                default: writes = 1'b0;
            endcase
        end else begin
            dest = rt;
            case (opc)
                OP_ADDIU: res = a + sext;
                OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OP_ANDI:  res = a & zext;
                OP_ORI:   res = a | zext;
                OP_XORI:  res = a ^ zext;
                OP_LUI:   res = {imm, 16'h0000};
                default:  writes = 1'b0;
            endcase
        end
        // r0 stays zero and is never reported
        if (writes && dest != 5'd0) begin
            model_regs[dest] = res;
            exp_dest.push_back(dest);
            exp_data.push_back(res);
            exp_total++;
        end
    endtask

    task automatic check_writeback(input string lane, input logic [4:0] dest,
                                   input logic [31:0] data);
        logic [4:0]  e_dest;
        logic [31:0] e_data;
        assert (exp_dest.size() != 0) else begin
            other_errs++;
            $display("At %0t the %s lane wrote r%0d although no write was pending",
                     $time, lane, dest);
        end
        if (exp_dest.size() != 0) begin
            e_dest = exp_dest.pop_front();
            e_data = exp_data.pop_front();
            retired++;
            assert (dest == e_dest) else begin
                value_errs++;
                $display("ERR %0t wb_%s_dest got %0d expected %0d", $time, lane, dest, e_dest);
            end
            assert (data == e_data) else begin
                value_errs++;
                $display("ERR %0t wb_%s_data got %h expected %h", $time, lane, data, e_data);
            end
        end
    endtask

    // Check writebacks, take credits back and maybe send a word each clock
    task automatic step_cycle(input bit may_send);
        logic [31:0] word;
        @(negedge clk);
        if (wb_master_en) begin
            check_writeback("master", wb_master_dest, wb_master_data);
        end
        if (wb_slave_en) begin
            check_writeback("slave", wb_slave_dest, wb_slave_data);
        end
        credits += inst_credit;
        assert (credits <= QUEUE_DEPTH) else begin
            other_errs++;
            $display("At %0t more credits came back than were spent", $time);
        end
        inst_valid = 1'b0;
        if (may_send && sent < NUM_INST && credits > 0 && rand_below(4) != 0) begin
            word = make_instruction();
            run_model(word);
            inst_data  = word;
            inst_valid = 1'b1;
            credits--;
            sent++;
        end
    endtask

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_data  = '0;
        value_errs = 0;
        other_errs = 0;
        retired    = 0;
        exp_total  = 0;
        sent       = 0;
        credits    = QUEUE_DEPTH;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(negedge clk);
        assert (inst_credit == 2'd0) else begin
            value_errs++;
            $display("ERR %0t inst_credit got %0d expected 0", $time, inst_credit);
        end
        rst = 1'b0;

        cycles = 0;
        while (sent < NUM_INST && cycles < SEND_LIMIT) begin
            step_cycle(1'b1);
            cycles++;
        end
        if (sent < NUM_INST) begin
            other_errs++;
            $display("Timed out after sending %0d of %0d instructions", sent, NUM_INST);
        end

        // Drain until every write retired and all credits are back
        cycles = 0;
        while ((exp_dest.size() != 0 || credits != QUEUE_DEPTH) && cycles < DRAIN_LIMIT) begin
            step_cycle(1'b0);
            cycles++;
        end
        assert (retired == exp_total) else begin
            other_errs++;
            $display("Timed out with %0d of %0d writes retired", retired, exp_total);
        end
        assert (credits == QUEUE_DEPTH) else begin
            other_errs++;
            $display("Only %0d of %0d credits came back", credits, QUEUE_DEPTH);
        end

        // Idle pipe must stay quiet
        repeat (4) step_cycle(1'b0);

        $display("Retired %0d of %0d writes, %0d value errors, %0d other errors",
                 retired, exp_total, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/dual_issue_pkg.sv
hdl/inst_queue.sv
hdl/inst_decoder.sv
hdl/issue_ctrl.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/int_alu.sv
hdl/dual_issue_core.sv
tb/tb_dual_issue.sv
